/* Bender.yml */
package:
  name: uart_rx

sources:
  # Packages come first.
  - files:
      - design/uartLinePkg.sv
      - design/rxReportPkg.sv

  - files:
      - design/rxLineFront.sv
      - design/rxChannel.sv
      - design/rxCollector.sv
      - design/uartRxTop.sv

  - target: simulation
    files:
      - sim/tbUartRx.sv

/* all.f */
design/uartLinePkg.sv
design/rxReportPkg.sv
design/rxLineFront.sv
design/rxChannel.sv
design/rxCollector.sv
design/uartRxTop.sv
sim/tbUartRx.sv

/* design/rxChannel.sv */
`timescale 1ns/100ps

module rxChannel #(
	parameter int DataBits = 8,
	parameter int StopBits = 2
) (
	input  logic                Clk,
	input  logic                rstN,
	input  logic                sampleTick,
	input  logic                rxSync,
	output logic                lineIdle,
	output logic                frameDone,
	output logic                frameOk,
	output logic [DataBits-1:0] frameData,
	output logic [2:0]          frameErr
);

	localparam int PhaseWidth = $clog2(uartLinePkg::OversampleRate);
	localparam int MaxBits = (DataBits > StopBits) ? DataBits : StopBits;
	localparam int CountWidth = $clog2(MaxBits + 1);
	localparam logic [PhaseWidth-1:0] HalfBit =
		PhaseWidth'(uartLinePkg::OversampleRate / 2 - 1);
	localparam logic [PhaseWidth-1:0] FullBit =
		PhaseWidth'(uartLinePkg::OversampleRate - 1);
	localparam logic [CountWidth-1:0] LastData = CountWidth'(DataBits - 1);
	localparam logic [CountWidth-1:0] LastStop = CountWidth'(StopBits - 1);

	uartLinePkg::rxStateT  state;
	logic [PhaseWidth-1:0] phase;    // Ticks since the last sample point.
	logic [CountWidth-1:0] bitCount;
	logic [DataBits-1:0]   shiftReg;
	logic                  parityReg;
	logic [StopBits-1:0]   stopReg;
	logic                  sampleNow;
	logic                  framingErr;

	// Start bit is confirmed at half a bit and the rest at full bit spacing.
	assign sampleNow = sampleTick &&
		((state == uartLinePkg::StartBit) ? (phase == HalfBit) : (phase == FullBit));

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= uartLinePkg::Idle;
			phase <= '0;
			bitCount <= '0;
		end
		else
		begin
			if (state == uartLinePkg::Idle || sampleNow)
				phase <= '0;
			else if (sampleTick)
				phase <= phase + 1'b1;

			case (state)
				uartLinePkg::Idle:
					if (sampleTick && !rxSync)
						state <= uartLinePkg::StartBit;
				uartLinePkg::StartBit:
					if (sampleNow)
					begin
						bitCount <= '0;
						if (rxSync)
							state <= uartLinePkg::Idle; // Glitch and not a start bit.
						else
							state <= uartLinePkg::DataBits;
					end
				uartLinePkg::DataBits:
					if (sampleNow)
					begin
						if (bitCount == LastData)
						begin
							bitCount <= '0;
							state <= uartLinePkg::ParityBit;
						end
						else
							bitCount <= bitCount + 1'b1;
					end
				uartLinePkg::ParityBit:
					if (sampleNow)
						state <= uartLinePkg::StopBits;
				uartLinePkg::StopBits:
					if (sampleNow)
					begin
						if (bitCount == LastStop)
						begin
							bitCount <= '0;
							state <= uartLinePkg::Done;
						end
						else
							bitCount <= bitCount + 1'b1;
					end
				default:
					state <= uartLinePkg::Idle; // Done lasts one cycle.
			endcase
		end
	end

	// Sampled bits land in the same clock as their sample point.
	always_ff @(posedge Clk)
	begin
		if (sampleNow)
		begin
			case (state)
				uartLinePkg::DataBits:
					shiftReg <= (shiftReg << 1) | DataBits'(rxSync);
				uartLinePkg::ParityBit:
					parityReg <= rxSync;
				uartLinePkg::StopBits:
					stopReg <= (stopReg << 1) | StopBits'(rxSync);
				default:
					;
			endcase
		end
	end

	assign framingErr = (stopReg != '1);

	assign frameErr[uartLinePkg::ErrFraming] = framingErr;
	assign frameErr[uartLinePkg::ErrParity] = (parityReg != ^shiftReg); // Even parity.
	assign frameErr[uartLinePkg::ErrBreak] = framingErr && (shiftReg == '0);

	// Good stop bits and matching parity.
	assign frameOk = (stopReg == '1) && (parityReg == ^shiftReg);
	assign frameData = shiftReg;
	assign frameDone = (state == uartLinePkg::Done);
	assign lineIdle = (state == uartLinePkg::Idle);

	assert property (@(posedge Clk) disable iff (!rstN) frameDone |=> lineIdle)
	else
		$error("Channel not idle after Done");

	assert property (@(posedge Clk) disable iff (!rstN) frameDone |-> !$isunknown(frameData))
	else
		$error("Unknown frameData on frameDone");

	assert property (@(posedge Clk) disable iff (!rstN)
		frameDone |-> (frameOk == (frameErr == 3'b000)))
	else
		$error("frameOk disagrees with frameErr");

endmodule

/* design/rxCollector.sv */
`timescale 1ns/100ps

module rxCollector #(
	parameter int Channels = 4,
	parameter int DataBits = 8
) (
	input  logic                                Clk,
	input  logic                                rstN,
	input  logic [Channels-1:0]                 frameDone,
	input  logic [Channels-1:0]                 frameOk,
	input  logic [DataBits-1:0]                 frameData [Channels],
	input  logic [2:0]                          frameErr [Channels],
	output logic                                reportValid,
	output logic [rxReportPkg::ChanIdWidth-1:0] reportChan,
	output rxReportPkg::reportKindT             reportKind,
	output rxReportPkg::reportPayloadT          reportPayload
);

	localparam int IdWidth = rxReportPkg::ChanIdWidth;

	logic [Channels-1:0]        pendValid;
	rxReportPkg::reportKindT    pendKind [Channels];
	rxReportPkg::reportPayloadT pendPayload [Channels];
	rxReportPkg::reportKindT    newKind [Channels];
	rxReportPkg::reportPayloadT newPayload [Channels];
	logic [Channels-1:0]        overrun;
	logic [Channels-1:0]        grant;
	logic [IdWidth-1:0]         grantIdx;
	logic [IdWidth-1:0]         lastServed;

	// Round-robin search starting after the channel served last.
	always_comb
	begin
		int idx;
		grant = '0;
		grantIdx = lastServed;
		for (int k = 1; k <= Channels; k++)
		begin
			idx = (int'(lastServed) + k) % Channels;
			if (grant == '0 && pendValid[idx])
			begin
				grant[idx] = 1'b1;
				grantIdx = IdWidth'(idx);
			end
		end
	end

	// An entry drained this cycle is not lost, so only a stale one counts.
	always_comb
	begin
		for (int i = 0; i < Channels; i++)
		begin
			overrun[i] = pendValid[i] && !grant[i];
			newPayload[i] = '0;
			if (frameOk[i] && !overrun[i])
			begin
				newKind[i] = rxReportPkg::KindData;
				newPayload[i].data = rxReportPkg::PayloadWidth'(frameData[i]);
			end
			else
			begin
				newKind[i] = rxReportPkg::KindError;
				newPayload[i].err.overrun = overrun[i];
				newPayload[i].err.framing = frameErr[i][uartLinePkg::ErrFraming];
				newPayload[i].err.parity = frameErr[i][uartLinePkg::ErrParity];
				newPayload[i].err.breakFlag = frameErr[i][uartLinePkg::ErrBreak];
			end
		end
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pendValid <= '0;
			lastServed <= IdWidth'(Channels - 1); // First search starts at channel 0.
		end
		else
		begin
			if (grant != '0)
				lastServed <= grantIdx;
			for (int i = 0; i < Channels; i++)
			begin
				if (frameDone[i])
					pendValid[i] <= 1'b1; // New strobe wins over the drain.
				else if (grant[i])
					pendValid[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		for (int i = 0; i < Channels; i++)
		begin
			if (frameDone[i])
			begin
				pendKind[i] <= newKind[i];
				pendPayload[i] <= newPayload[i];
			end
		end
	end

	assign reportValid = (grant != '0);
	assign reportChan = grantIdx;
	assign reportKind = pendKind[grantIdx];
	assign reportPayload = pendPayload[grantIdx];

	assert property (@(posedge Clk) disable iff (!rstN)
		reportValid |->
			(($past(pendValid | frameDone) & (Channels'(1) << reportChan)) != '0))
	else
		$error("Report from a channel with nothing pending");

endmodule

/* design/rxLineFront.sv */
`timescale 1ns/100ps

module rxLineFront #(
	parameter int Channels = 4,
	parameter int ClksPerTick = 2
) (
	input  logic                Clk,
	input  logic                rstN,
	input  logic [Channels-1:0] rxLine,
	output logic [Channels-1:0] rxSync,
	output logic                sampleTick
);

	localparam int TickWidth = (ClksPerTick > 1) ? $clog2(ClksPerTick) : 1;
	localparam logic [TickWidth-1:0] TickLast = TickWidth'(ClksPerTick - 1);

	logic [Channels-1:0]  syncMeta; // First synchronizer stage.
	logic [TickWidth-1:0] tickCount;

	// Two-flop synchronizer per line with a high idle level.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			syncMeta <= '1;
			rxSync <= '1;
		end
		else
		begin
			syncMeta <= rxLine;
			rxSync <= syncMeta;
		end
	end

	// Free-running oversample divider.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			tickCount <= '0;
		else if (tickCount == TickLast)
			tickCount <= '0;
		else
			tickCount <= tickCount + 1'b1;
	end

	assign sampleTick = (tickCount == TickLast); // Shared by all channels.

	// The divider must leave a gap between ticks.
	assert property (@(posedge Clk) disable iff (!rstN)
		(ClksPerTick > 1) && sampleTick |=> !sampleTick)
	else
		$error("sampleTick high in two consecutive cycles");

endmodule

/* design/rxReportPkg.sv */
package rxReportPkg;

	localparam int ChanIdWidth = 2; // Four channels.
	localparam int PayloadWidth = 8;

	typedef enum logic
	{
		KindData,
		KindError
	} reportKindT;

	// Flag order matches the channel error vector in the low bits.
	typedef struct packed
	{
		logic [PayloadWidth-5:0] pad;
		logic                    overrun;
		logic                    framing;
		logic                    parity;
		logic                    breakFlag;
	} errRecordT;

	// One payload word decoded by the report kind.
	typedef union packed
	{
		logic [PayloadWidth-1:0] data; // KindData.
		errRecordT               err;  // KindError.
	} reportPayloadT;

endpackage

/* design/uartLinePkg.sv */
package uartLinePkg;

	// Oversample ticks per serial bit.
	localparam int OversampleRate = 16;

	// Receiver FSM states.
	typedef enum logic [2:0]
	{
		Idle,      // Line high and waiting for a start bit.
		StartBit,  // Falling edge seen and waiting for the bit center.
		DataBits,  // Data bits with the MSB first.
		ParityBit, // Even parity.
		StopBits,  // One or more stop bits.
		Done       // Result strobe for one cycle.
	} rxStateT;

	// Positions within the 3-bit error vector of a channel.
	localparam int ErrBreak = 0;
	localparam int ErrParity = 1;
	localparam int ErrFraming = 2;

endpackage

/* design/uartRxTop.sv */
`timescale 1ns/100ps

module uartRxTop #(
	parameter int Channels = 4,
	parameter int DataBits = 8,
	parameter int StopBits = 2,
	parameter int ClksPerTick = 2
) (
	input  logic                                Clk,
	input  logic                                rstN,
	input  logic [Channels-1:0]                 rxLine,
	output logic [Channels-1:0]                 lineIdle,
	output logic                                reportValid,
	output logic [rxReportPkg::ChanIdWidth-1:0] reportChan,
	output rxReportPkg::reportKindT             reportKind,
	output rxReportPkg::reportPayloadT          reportPayload
);

	logic [Channels-1:0] rxSync;
	logic                sampleTick;
	logic [Channels-1:0] frameDone;
	logic [Channels-1:0] frameOk;
	logic [DataBits-1:0] frameData [Channels];
	logic [2:0]          frameErr [Channels];

	rxLineFront #(
		.Channels(Channels),
		.ClksPerTick(ClksPerTick)
	) rxLineFront_i (
		.Clk(Clk),
		.rstN(rstN),
		.rxLine(rxLine),
		.rxSync(rxSync),
		.sampleTick(sampleTick)
	);

	for (genvar ch = 0; ch < Channels; ch++)
	begin : genChannel
		rxChannel #(
			.DataBits(DataBits),
			.StopBits(StopBits)
		) rxChannel_i (
			.Clk(Clk),
			.rstN(rstN),
			.sampleTick(sampleTick),
			.rxSync(rxSync[ch]),
			.lineIdle(lineIdle[ch]),
			.frameDone(frameDone[ch]),
			.frameOk(frameOk[ch]),
			.frameData(frameData[ch]),
			.frameErr(frameErr[ch])
		);
	end

	rxCollector #(
		.Channels(Channels),
		.DataBits(DataBits)
	) rxCollector_i (
		.Clk(Clk),
		.rstN(rstN),
		.frameDone(frameDone),
		.frameOk(frameOk),
		.frameData(frameData),
		.frameErr(frameErr),
		.reportValid(reportValid),
		.reportChan(reportChan),
		.reportKind(reportKind),
		.reportPayload(reportPayload)
	);

endmodule

/* sim/tbUartRx.sv */
`timescale 1ns/100ps

module tbUartRx;

	localparam int Channels = 4;
	localparam int DataBits = 8;
	localparam int StopBits = 2;
	localparam int ClksPerTick = 2;
	localparam int BitCycles = uartLinePkg::OversampleRate * ClksPerTick;
	localparam int FrameCycles = (1 + DataBits + 1 + StopBits) * BitCycles;
	localparam int TimeoutCycles = 40 * FrameCycles + 1000;

	logic                                Clk;
	logic                                rstN;
	logic [Channels-1:0]                 rxLine;
	logic [Channels-1:0]                 lineIdle;
	logic                                reportValid;
	logic [rxReportPkg::ChanIdWidth-1:0] reportChan;
	rxReportPkg::reportKindT             reportKind;
	rxReportPkg::reportPayloadT          reportPayload;

	logic [10:0]             expQ [$]; // {chan, kind, payload} per character sent.
	logic                    expHit;
	rxReportPkg::reportKindT expKind;
	logic [7:0]              expPayload;
	logic [Channels-1:0]     idleCheck; // Channels that must be idle now.
	logic [Channels-1:0]     inFrame;   // Channels in the middle of a character.
	logic                    started;
	logic [31:0]             rngState;
	logic [7:0]              burst [Channels];
	int                      errorCount;
	int                      charCount;
	int                      reportCount;
	int                      cycleCount;

	uartRxTop #(
		.Channels(Channels),
		.DataBits(DataBits),
		.StopBits(StopBits),
		.ClksPerTick(ClksPerTick)
	) uartRxTop_i (
		.Clk(Clk),
		.rstN(rstN),
		.rxLine(rxLine),
		.lineIdle(lineIdle),
		.reportValid(reportValid),
		.reportChan(reportChan),
		.reportKind(reportKind),
		.reportPayload(reportPayload)
	);

	always #50 Clk = ~Clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Expected report of one character by the decoding rule.
	function automatic logic [10:0] expectedEntry(input int ch, input logic [7:0] data,
		input logic badParity, input logic lowStop);
		rxReportPkg::errRecordT rec;
		rec = '0;
		rec.parity = badParity;
		rec.framing = lowStop;
		rec.breakFlag = lowStop && (data == 8'h00);
		if (rec == '0)
			return {2'(ch), rxReportPkg::KindData, data};
		else
			return {2'(ch), rxReportPkg::KindError, rec};
	endfunction

	function automatic int findExpected(input logic [1:0] ch);
		for (int i = 0; i < expQ.size(); i++)
			if (expQ[i][10:9] == ch)
				return i;
		return -1;
	endfunction

	task automatic driveBit(input int ch, input logic b);
		rxLine[ch] = b;
		repeat (BitCycles) @(negedge Clk);
	endtask

	task automatic sendChar(input int ch, input logic [7:0] data, input logic badParity,
		input logic lowStop);
		expQ.push_back(expectedEntry(ch, data, badParity, lowStop));
		charCount++;
		started = 1'b1;
		idleCheck[ch] = 1'b0;
		driveBit(ch, 1'b0);
		inFrame[ch] = 1'b1;
		for (int i = DataBits - 1; i >= 0; i--)
			driveBit(ch, data[i]);
		driveBit(ch, (^data) ^ badParity); // Even parity unless badParity flips it.
		inFrame[ch] = 1'b0;
		for (int s = 0; s < StopBits; s++)
			driveBit(ch, !(lowStop && s == 0)); // First stop bit low.
		idleCheck[ch] = 1'b1;
	endtask

	// Short low pulse that the channel must reject.
	task automatic sendGlitch(input int ch);
		idleCheck[ch] = 1'b0;
		rxLine[ch] = 1'b0;
		repeat (10) @(negedge Clk);
		rxLine[ch] = 1'b1;
		repeat (BitCycles - 10) @(negedge Clk);
		idleCheck[ch] = 1'b1;
	endtask

	// Reports are stable in the low clock phase.
	always @(negedge Clk)
	begin
		int idx;
		if (rstN && reportValid)
		begin
			idx = findExpected(reportChan);
			expHit = (idx >= 0);
			if (idx >= 0)
			begin
				expKind = rxReportPkg::reportKindT'(expQ[idx][8]);
				expPayload = expQ[idx][7:0];
				expQ.delete(idx);
			end
			reportCount++;
		end
	end

	quietBeforeStart: assert property (@(posedge Clk) disable iff (!rstN)
		!started |-> !reportValid)
	else
	begin
		errorCount++;
		$display("CHECK FAILED at %0t: report before the first start bit", $time);
	end

	idleWhenExpected: assert property (@(posedge Clk) disable iff (!rstN)
		(idleCheck & ~lineIdle) == '0)
	else
	begin
		errorCount++;
		$display("CHECK FAILED at %0t: lineIdle %b low, expected idle %b", $time, lineIdle,
			idleCheck);
	end

	busyInFrame: assert property (@(posedge Clk) disable iff (!rstN)
		(inFrame & lineIdle) == '0)
	else
	begin
		errorCount++;
		$display("CHECK FAILED at %0t: lineIdle %b high inside a character", $time, lineIdle);
	end

	reportMatches: assert property (@(posedge Clk) disable iff (!rstN)
		reportValid |-> expHit && reportKind == expKind && reportPayload == expPayload)
	else
	begin
		errorCount++;
		$display("CHECK FAILED at %0t: channel %0d kind %0d payload %h, expected %0d %h (%0d)",
			$time, reportChan, reportKind, reportPayload, expKind, expPayload, expHit);
	end

	noOverrun: assert property (@(posedge Clk) disable iff (!rstN)
		reportValid && reportKind == rxReportPkg::KindError |-> !reportPayload.err.overrun)
	else
	begin
		errorCount++;
		$display("CHECK FAILED at %0t: overrun flag on channel %0d", $time, reportChan);
	end

	always @(posedge Clk)
	begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timed out after %0d cycles with %0d reports still missing", cycleCount,
				expQ.size());
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		Clk = 1'b0;
		rstN = 1'b0;
		rxLine = '1;
		idleCheck = '1;
		inFrame = '0;
		started = 1'b0;
		expHit = 1'b0;
		expKind = rxReportPkg::KindData;
		expPayload = '0;
		rngState = 32'h3195;
		errorCount = 0;
		charCount = 0;
		reportCount = 0;
		cycleCount = 0;
		repeat (10) @(negedge Clk);
		rstN = 1'b1;
		repeat (BitCycles) @(negedge Clk);

		// Good characters on one channel at a time.
		for (int ch = 0; ch < Channels; ch++)
			for (int n = 0; n < 2; n++)
			begin
				rngState = xorshift32(rngState);
				sendChar(ch, rngState[7:0], 1'b0, 1'b0);
			end

		// Error decoding.
		rngState = xorshift32(rngState);
		sendChar(rngState[9:8], rngState[7:0], 1'b1, 1'b0);
		rngState = xorshift32(rngState);
		sendChar(rngState[9:8], rngState[7:0] | 8'h01, 1'b0, 1'b1);
		rngState = xorshift32(rngState);
		sendChar(rngState[9:8], 8'h00, 1'b0, 1'b1);

		// All channels at once and a cycle apart.
		for (int ch = 0; ch < Channels; ch++)
		begin
			rngState = xorshift32(rngState);
			burst[ch] = rngState[7:0];
		end
		fork
			sendChar(0, burst[0], 1'b0, 1'b0);
			begin
				@(negedge Clk);
				sendChar(1, burst[1], 1'b0, 1'b0);
			end
			begin
				repeat (2) @(negedge Clk);
				sendChar(2, burst[2], 1'b0, 1'b0);
			end
			begin
				repeat (3) @(negedge Clk);
				sendChar(3, burst[3], 1'b0, 1'b0);
			end
		join

		rngState = xorshift32(rngState);
		sendGlitch(rngState[1:0]);
		repeat (FrameCycles) @(negedge Clk); // Room for a report from a missed glitch.

		while (expQ.size() != 0)
			@(negedge Clk);
		repeat (BitCycles) @(negedge Clk);

		if (reportCount != charCount)
		begin
			errorCount++;
			$display("CHECK FAILED at %0t: got %0d reports for %0d characters sent", $time,
				reportCount, charCount);
		end
		$display("Errors: %0d, characters: %0d, reports: %0d", errorCount, charCount,
			reportCount);
		if (errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
